/* rtl/cpu_macros.svh */
// Widths, the I/O map and the debug register index shared by the core and the testbench.
// I/O decode in the core looks only at address bits 17:16.
`ifndef CPU_MACROS_SVH
`define CPU_MACROS_SVH

// data and address width
`define XLEN 32

// register index width
`define REG_IDX_W 5

// output byte port and program stop
`define IO_OUT_ADDR 32'h0003_0000
`define IO_STOP_ADDR 32'h0003_0004

// register mirrored on dbgreg_dout
`define DBG_REG 5'd10

`endif

/* rtl/cpu_pkg.sv */
// Types carried between the pipeline stages and the memory controller.
`default_nettype none

package cpu_pkg;

    // execute operations, immediate forms share the register opcode
    typedef enum logic [2:0] {
        OP_ADD,
        OP_SUB,
        OP_AND,
        OP_OR,
        OP_XOR,
        OP_LUI,
        OP_SB
    } alu_op_e;

    // byte bus sequencing
    typedef enum logic [1:0] {
        ST_IDLE,
        ST_FETCH,
        ST_STORE
    } mem_state_e;

endpackage

`default_nettype wire

/* rtl/memctrl.sv */
// Byte bus controller for fetch and SB. Stores win over a fetch not yet started.
// A cycle with mem_wr high is a write even while rdy_in is low, so the memory side must gate it.
`timescale 1ns/1ps
`default_nettype none
`include "cpu_macros.svh"

module memctrl (
    input  logic              clk_in,
    input  logic              rst_n,
    input  logic              rdy_in,
    input  logic [7:0]        mem_din,
    output logic [7:0]        mem_dout,
    output logic [`XLEN-1:0]  mem_a,
    output logic              mem_wr,
    input  logic              io_buffer_full,
    input  logic              fetch_req,
    input  logic [`XLEN-1:0]  fetch_pc,
    output logic              fetch_done,
    output logic [`XLEN-1:0]  fetch_inst,
    input  logic              st_req,
    input  logic [`XLEN-1:0]  st_addr,
    input  logic [7:0]        st_data,
    output logic              st_done
);
    import cpu_pkg::*;

    localparam logic [`XLEN-1:0] IO_BASE = `IO_OUT_ADDR;

    mem_state_e state_q;
    // byte k-1 is on mem_din when cnt_q is k
    logic [2:0] cnt_q;
    logic       mem_is_io;

    assign mem_is_io = (mem_a[17:16] == IO_BASE[17:16]);

    // an I/O write is held off while the UART buffer is full
    assign mem_wr  = (state_q == ST_STORE) && !(mem_is_io && io_buffer_full);
    assign st_done = mem_wr;

    always_ff @(posedge clk_in or negedge rst_n) begin
        if (!rst_n) begin
            state_q    <= ST_IDLE;
            cnt_q      <= '0;
            mem_a      <= '0;
            mem_dout   <= '0;
            fetch_done <= 1'b0;
        end else if (rdy_in) begin
            fetch_done <= 1'b0;
            case (state_q)
                ST_IDLE: begin
                    if (st_req) begin
                        mem_a    <= st_addr;
                        mem_dout <= st_data;
                        state_q  <= ST_STORE;
                    end else if (fetch_req && !fetch_done) begin
                        // fetch_done high means the request is already served
                        mem_a   <= fetch_pc;
                        cnt_q   <= '0;
                        state_q <= ST_FETCH;
                    end
                end
                ST_FETCH: begin
                    cnt_q <= cnt_q + 3'd1;
                    if (cnt_q < 3'd3) begin
                        mem_a <= mem_a + 32'd1;
                    end
                    if (cnt_q == 3'd4) begin
                        fetch_done <= 1'b1;
                        state_q    <= ST_IDLE;
                    end
                end
                ST_STORE: begin
                    if (mem_wr) begin
                        state_q <= ST_IDLE;
                    end
                end
                default: state_q <= ST_IDLE;
            endcase
        end
    end

    // bytes shift in from the top and land little endian
    always_ff @(posedge clk_in) begin
        if (rdy_in && state_q == ST_FETCH && cnt_q != 3'd0) begin
            fetch_inst <= {mem_din, fetch_inst[31:8]};
        end
    end

    // execute keeps a store request and its operands steady until the bus takes it
    a_st_req_hold: assert property (
        @(posedge clk_in) disable iff (!rst_n)
        st_req && !st_done |=> st_req && $stable(st_addr) && $stable(st_data)
    );

endmodule

`default_nettype wire

/* rtl/fetcher.sv */
// Holds the pc and one fetched instruction. One fetch is outstanding at most.
`timescale 1ns/1ps
`default_nettype none
`include "cpu_macros.svh"

module fetcher (
    input  logic              clk_in,
    input  logic              rst_n,
    input  logic              rdy_in,
    output logic              fetch_req,
    output logic [`XLEN-1:0]  fetch_pc,
    input  logic              fetch_done,
    input  logic [`XLEN-1:0]  fetch_inst,
    output logic              if_valid,
    output logic [`XLEN-1:0]  if_inst,
    output logic [`XLEN-1:0]  if_pc,
    input  logic              if_ready
);

    logic             req_q;
    logic [`XLEN-1:0] pc_q;
    logic             out_free;

    assign fetch_req = req_q;
    assign fetch_pc  = pc_q;

    // output slot empty now or emptied at this edge
    assign out_free = !if_valid || if_ready;

    always_ff @(posedge clk_in or negedge rst_n) begin
        if (!rst_n) begin
            req_q    <= 1'b0;
            pc_q     <= '0;
            if_valid <= 1'b0;
        end else if (rdy_in) begin
            if (if_valid && if_ready) begin
                if_valid <= 1'b0;
            end
            if (req_q && fetch_done) begin
                req_q    <= 1'b0;
                pc_q     <= pc_q + 32'd4;
                if_valid <= 1'b1;
            end else if (!req_q && out_free) begin
                req_q <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk_in) begin
        if (rdy_in && req_q && fetch_done) begin
            if_inst <= fetch_inst;
            if_pc   <= pc_q;
        end
    end

    a_if_hold: assert property (
        @(posedge clk_in) disable iff (!rst_n)
        if_valid && !if_ready |=> $stable(if_inst) && $stable(if_pc)
    );

endmodule

`default_nettype wire

/* rtl/decoder.sv */
// Decode and operand read. Unsupported encodings become ADDI x0 and have no effect.
// No bypass, a source waits until its busy bit clears.
`timescale 1ns/1ps
`default_nettype none
`include "cpu_macros.svh"

module decoder (
    input  logic                  clk_in,
    input  logic                  rst_n,
    input  logic                  rdy_in,
    input  logic                  if_valid,
    input  logic [`XLEN-1:0]      if_inst,
    input  logic [`XLEN-1:0]      if_pc,
    output logic                  if_ready,
    output logic [`REG_IDX_W-1:0] rs1_idx,
    output logic [`REG_IDX_W-1:0] rs2_idx,
    input  logic [`XLEN-1:0]      rs1_data,
    input  logic [`XLEN-1:0]      rs2_data,
    input  logic                  rs1_busy,
    input  logic                  rs2_busy,
    output logic                  claim_en,
    output logic [`REG_IDX_W-1:0] claim_idx,
    output logic                  id_valid,
    output cpu_pkg::alu_op_e      id_op,
    output logic [`REG_IDX_W-1:0] id_rd,
    output logic [`XLEN-1:0]      id_a,
    output logic [`XLEN-1:0]      id_b,
    output logic [`XLEN-1:0]      id_imm,
    input  logic                  id_ready
);
    import cpu_pkg::*;

    typedef enum logic [6:0] {
        OPC_REG   = 7'b0110011,
        OPC_IMM   = 7'b0010011,
        OPC_LUI   = 7'b0110111,
        OPC_STORE = 7'b0100011
    } rv_opcode_e;

    logic [2:0]            funct3;
    logic [6:0]            funct7;
    logic [`XLEN-1:0]      imm_i;
    logic [`XLEN-1:0]      imm_s;
    logic [`XLEN-1:0]      imm_u;
    alu_op_e               op_d;
    logic [`REG_IDX_W-1:0] rd_d;
    logic [`XLEN-1:0]      imm_d;
    logic                  use_rs1;
    logic                  use_rs2;
    logic                  use_imm_b;
    logic                  ok;
    logic                  stall;
    logic                  fire;
    logic                  seen_q;
    logic [`XLEN-1:0]      last_pc_q;

    assign funct3  = if_inst[14:12];
    assign funct7  = if_inst[31:25];
    assign rs1_idx = if_inst[19:15];
    assign rs2_idx = if_inst[24:20];
    assign imm_i   = {{20{if_inst[31]}}, if_inst[31:20]};
    assign imm_s   = {{20{if_inst[31]}}, if_inst[31:25], if_inst[11:7]};
    assign imm_u   = {if_inst[31:12], 12'b0};

    always_comb begin
        op_d      = OP_ADD;
        rd_d      = if_inst[11:7];
        imm_d     = '0;
        use_rs1   = 1'b1;
        use_rs2   = 1'b0;
        use_imm_b = 1'b0;
        ok        = 1'b1;
        case (rv_opcode_e'(if_inst[6:0]))
            OPC_REG: begin
                use_rs2 = 1'b1;
                ok = (funct7 == 7'b0000000) || (funct7 == 7'b0100000 && funct3 == 3'b000);
                case (funct3)
                    3'b000:  op_d = funct7[5] ? OP_SUB : OP_ADD;
                    3'b100:  op_d = OP_XOR;
                    3'b110:  op_d = OP_OR;
                    3'b111:  op_d = OP_AND;
                    default: ok = 1'b0;
                endcase
            end
            OPC_IMM: begin
                use_imm_b = 1'b1;
                case (funct3)
                    3'b000:  op_d = OP_ADD;
                    3'b100:  op_d = OP_XOR;
                    3'b110:  op_d = OP_OR;
                    3'b111:  op_d = OP_AND;
                    default: ok = 1'b0;
                endcase
            end
            OPC_LUI: begin
                op_d    = OP_LUI;
                imm_d   = imm_u;
                use_rs1 = 1'b0;
            end
            OPC_STORE: begin
                // only SB, rs2 carries the byte
                op_d    = OP_SB;
                rd_d    = '0;
                imm_d   = imm_s;
                use_rs2 = 1'b1;
                ok      = (funct3 == 3'b000);
            end
            default: ok = 1'b0;
        endcase
        if (!ok) begin
            op_d      = OP_ADD;
            rd_d      = '0;
            use_rs1   = 1'b0;
            use_rs2   = 1'b0;
            use_imm_b = 1'b0;
        end
    end

    // a second writer of the same rd waits until the first leaves the id slot
    assign stall = (use_rs1 && rs1_busy) || (use_rs2 && rs2_busy) ||
                   (id_valid && rd_d != '0 && id_rd == rd_d);

    assign if_ready  = (!id_valid || id_ready) && !stall;
    assign fire      = if_valid && if_ready;
    assign claim_en  = fire && (rd_d != '0);
    assign claim_idx = rd_d;

    always_ff @(posedge clk_in or negedge rst_n) begin
        if (!rst_n) begin
            id_valid  <= 1'b0;
            seen_q    <= 1'b0;
            last_pc_q <= '0;
        end else if (rdy_in) begin
            if (fire) begin
                id_valid  <= 1'b1;
                seen_q    <= 1'b1;
                last_pc_q <= if_pc;
            end else if (id_ready) begin
                id_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk_in) begin
        if (rdy_in && fire) begin
            id_op  <= op_d;
            id_rd  <= rd_d;
            id_a   <= rs1_data;
            id_b   <= use_imm_b ? imm_i : rs2_data;
            id_imm <= imm_d;
        end
    end

    // with no branches, decode must see the program in strict pc order
    a_pc_order: assert property (
        @(posedge clk_in) disable iff (!rst_n)
        rdy_in && fire && seen_q |-> if_pc == last_pc_q + 32'd4
    );

endmodule

`default_nettype wire

/* rtl/regfile.sv */
// 32 registers with one busy bit each. No write-through, a read sees the old value.
`timescale 1ns/1ps
`default_nettype none
`include "cpu_macros.svh"

module regfile (
    input  logic                  clk_in,
    input  logic                  rst_n,
    input  logic                  rdy_in,
    input  logic [`REG_IDX_W-1:0] rs1_idx,
    input  logic [`REG_IDX_W-1:0] rs2_idx,
    output logic [`XLEN-1:0]      rs1_data,
    output logic [`XLEN-1:0]      rs2_data,
    output logic                  rs1_busy,
    output logic                  rs2_busy,
    input  logic                  claim_en,
    input  logic [`REG_IDX_W-1:0] claim_idx,
    input  logic                  wb_en,
    input  logic [`REG_IDX_W-1:0] wb_idx,
    input  logic [`XLEN-1:0]      wb_data,
    output logic [`XLEN-1:0]      dbgreg_dout
);

    logic [`XLEN-1:0] regs [32];
    logic [31:0]      busy_q;

    assign rs1_data    = regs[rs1_idx];
    assign rs2_data    = regs[rs2_idx];
    assign rs1_busy    = busy_q[rs1_idx];
    assign rs2_busy    = busy_q[rs2_idx];
    assign dbgreg_dout = regs[`DBG_REG];

    always_ff @(posedge clk_in or negedge rst_n) begin
        if (!rst_n) begin
            busy_q <= '0;
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (rdy_in) begin
            if (wb_en && wb_idx != '0) begin
                regs[wb_idx]   <= wb_data;
                busy_q[wb_idx] <= 1'b0;
            end
            // claim after writeback so a same-cycle claim keeps the bit set
            if (claim_en && claim_idx != '0) begin
                busy_q[claim_idx] <= 1'b1;
            end
        end
    end

    a_wb_claimed: assert property (
        @(posedge clk_in) disable iff (!rst_n)
        rdy_in && wb_en |-> busy_q[wb_idx]
    );

endmodule

`default_nettype wire

/* rtl/execute.sv */
// ALU with writeback one cycle after accept. An SB blocks the stage until the bus takes it.
`timescale 1ns/1ps
`default_nettype none
`include "cpu_macros.svh"

module execute (
    input  logic                  clk_in,
    input  logic                  rst_n,
    input  logic                  rdy_in,
    input  logic                  id_valid,
    input  cpu_pkg::alu_op_e      id_op,
    input  logic [`REG_IDX_W-1:0] id_rd,
    input  logic [`XLEN-1:0]      id_a,
    input  logic [`XLEN-1:0]      id_b,
    input  logic [`XLEN-1:0]      id_imm,
    output logic                  id_ready,
    output logic                  wb_en,
    output logic [`REG_IDX_W-1:0] wb_idx,
    output logic [`XLEN-1:0]      wb_data,
    output logic                  st_req,
    output logic [`XLEN-1:0]      st_addr,
    output logic [7:0]            st_data,
    input  logic                  st_done
);
    import cpu_pkg::*;

    logic             accept;
    logic             is_store;
    logic [`XLEN-1:0] alu_res;

    assign id_ready = !st_req || st_done;
    assign accept   = id_valid && id_ready;
    assign is_store = (id_op == OP_SB);

    always_comb begin
        case (id_op)
            OP_ADD:  alu_res = id_a + id_b;
            OP_SUB:  alu_res = id_a - id_b;
            OP_AND:  alu_res = id_a & id_b;
            OP_OR:   alu_res = id_a | id_b;
            OP_XOR:  alu_res = id_a ^ id_b;
            OP_LUI:  alu_res = id_imm;
            // store address
            default: alu_res = id_a + id_imm;
        endcase
    end

    always_ff @(posedge clk_in or negedge rst_n) begin
        if (!rst_n) begin
            wb_en  <= 1'b0;
            st_req <= 1'b0;
        end else if (rdy_in) begin
            wb_en <= 1'b0;
            if (st_req && st_done) begin
                st_req <= 1'b0;
            end
            if (accept) begin
                if (is_store) begin
                    st_req <= 1'b1;
                end else begin
                    // rd of x0 means no architectural effect
                    wb_en <= (id_rd != '0);
                end
            end
        end
    end

    always_ff @(posedge clk_in) begin
        if (rdy_in && accept) begin
            if (is_store) begin
                st_addr <= alu_res;
                st_data <= id_b[7:0];
            end else begin
                wb_idx  <= id_rd;
                wb_data <= alu_res;
            end
        end
    end

endmodule

`default_nettype wire

/* rtl/cpu.sv */
// RV32I subset core: register ALU ops, ALUI ops, LUI and SB only.
// Freezes completely while rdy_in is low, dbgreg_dout mirrors x10.
`timescale 1ns/1ps
`default_nettype none
`include "cpu_macros.svh"

module cpu (
    input  logic              clk_in,
    input  logic              rst_n,
    input  logic              rdy_in,
    input  logic [7:0]        mem_din,
    output logic [7:0]        mem_dout,
    output logic [`XLEN-1:0]  mem_a,
    output logic              mem_wr,
    input  logic              io_buffer_full,
    output logic [`XLEN-1:0]  dbgreg_dout
);
    import cpu_pkg::*;

    // fetch side of the bus
    logic                  fetch_req;
    logic [`XLEN-1:0]      fetch_pc;
    logic                  fetch_done;
    logic [`XLEN-1:0]      fetch_inst;

    // store side of the bus
    logic                  st_req;
    logic [`XLEN-1:0]      st_addr;
    logic [7:0]            st_data;
    logic                  st_done;

    // fetch to decode
    logic                  if_valid;
    logic [`XLEN-1:0]      if_inst;
    logic [`XLEN-1:0]      if_pc;
    logic                  if_ready;

    // register reads and scoreboard
    logic [`REG_IDX_W-1:0] rs1_idx;
    logic [`REG_IDX_W-1:0] rs2_idx;
    logic [`XLEN-1:0]      rs1_data;
    logic [`XLEN-1:0]      rs2_data;
    logic                  rs1_busy;
    logic                  rs2_busy;
    logic                  claim_en;
    logic [`REG_IDX_W-1:0] claim_idx;

    // decode to execute
    logic                  id_valid;
    alu_op_e               id_op;
    logic [`REG_IDX_W-1:0] id_rd;
    logic [`XLEN-1:0]      id_a;
    logic [`XLEN-1:0]      id_b;
    logic [`XLEN-1:0]      id_imm;
    logic                  id_ready;

    // writeback
    logic                  wb_en;
    logic [`REG_IDX_W-1:0] wb_idx;
    logic [`XLEN-1:0]      wb_data;

    // every port name matches its net
    memctrl u_memctrl (.*);
    fetcher u_fetcher (.*);
    decoder u_decoder (.*);
    regfile u_regfile (.*);
    execute u_execute (.*);

endmodule

`default_nettype wire

/* tests/tb_mem_model.sv */
// 128 KB byte memory, read data one cycle after the address, frozen while rdy_in is low.
// Addresses with bits 17:16 set are I/O and never reach the array.
`timescale 1ns/1ps
`default_nettype none
`include "cpu_macros.svh"

module tb_mem_model (
    input  logic              clk_in,
    input  logic              rdy_in,
    input  logic [`XLEN-1:0]  mem_a,
    input  logic              mem_wr,
    input  logic [7:0]        mem_dout,
    output logic [7:0]        mem_din,
    output logic              io_out_wr,
    output logic              io_stop_wr
);

    logic [7:0] mem [0:131071];
    logic       is_io;

    assign is_io      = (mem_a[17:16] == 2'b11);
    assign io_out_wr  = rdy_in && mem_wr && (mem_a == `IO_OUT_ADDR);
    assign io_stop_wr = rdy_in && mem_wr && (mem_a == `IO_STOP_ADDR);

    initial begin
        mem_din = 8'h00;
    end

    always @(posedge clk_in) begin
        if (rdy_in) begin
            mem_din <= is_io ? 8'h00 : mem[mem_a[16:0]];
            if (mem_wr && !is_io) begin
                mem[mem_a[16:0]] <= mem_dout;
            end
        end
    end

    task automatic clear_mem();
        for (int i = 0; i < 131072; i++) begin
            mem[i] = 8'h00;
        end
    endtask

    // little endian word
    task automatic load_word(input logic [31:0] addr, input logic [31:0] word);
        for (int i = 0; i < 4; i++) begin
            mem[addr[16:0] + i] = word[8*i +: 8];
        end
    endtask

endmodule

`default_nettype wire

/* tests/tb_cpu.sv */
// Runs three programs on the core with random rdy_in drops and a random I/O buffer-full.
// A reference model steps along as each program is built and predicts x10 and the output bytes.
`timescale 1ns/1ps
`default_nettype none
`include "cpu_macros.svh"

module tb_cpu;

    localparam int K_ADD = 0;
    localparam int K_SUB = 1;
    localparam int K_AND = 2;
    localparam int K_OR = 3;
    localparam int K_XOR = 4;
    localparam int K_ADDI = 5;
    localparam int K_ANDI = 6;
    localparam int K_ORI = 7;
    localparam int K_XORI = 8;
    localparam int K_LUI = 9;
    localparam int K_SB = 10;

    logic        clk_in;
    logic        rst_n;
    logic        rdy_in;
    logic        io_buffer_full;
    logic [7:0]  mem_din;
    logic [7:0]  mem_dout;
    logic [31:0] mem_a;
    logic        mem_wr;
    logic [31:0] dbgreg_dout;
    logic        io_out_wr;
    logic        io_stop_wr;

    logic [31:0] ref_regs [32];
    logic [7:0]  exp_out [$];
    logic [31:0] build_pc;
    int          inst_total;
    int          cycle_cnt;
    string       cur_test;
    logic        stop_seen;
    logic        rdy_seen;
    logic [31:0] last_a;
    logic [31:0] exp_next;

    cpu u_cpu (.*);

    tb_mem_model u_mem (
        .clk_in, .rdy_in, .mem_a, .mem_wr, .mem_dout, .mem_din, .io_out_wr, .io_stop_wr
    );

    task automatic report_mismatch(input string name, input string what,
                                   input logic [31:0] exp, input logic [31:0] act);
        $display("** FAIL **");
        $display("FAILED %s %s expected %h actual %h", name, what, exp, act);
        $fatal(1);
    endtask

    task automatic report_error(input string msg);
        $display("** FAIL **");
        $display("%s", msg);
        $fatal(1);
    endtask

    function automatic logic [31:0] encode_r(input int f3, input int f7, input int rd,
                                             input int rs1, input int rs2);
        return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], 7'b0110011};
    endfunction

    function automatic logic [31:0] encode_i(input int f3, input int rd, input int rs1,
                                             input int imm);
        return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], 7'b0010011};
    endfunction

    function automatic logic [31:0] encode_s(input int rs1, input int rs2, input int imm);
        return {imm[11:5], rs2[4:0], rs1[4:0], 3'b000, imm[4:0], 7'b0100011};
    endfunction

    function automatic logic [31:0] encode_u(input int rd, input int imm);
        return {imm[19:0], rd[4:0], 7'b0110111};
    endfunction

    // encode into memory and step the reference model
    task automatic add_inst(input int kind, input int rd, input int rs1, input int rs2,
                            input int imm);
        logic [31:0] word;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] si;
        logic [31:0] res;
        a  = ref_regs[rs1];
        b  = ref_regs[rs2];
        si = {{20{imm[11]}}, imm[11:0]};
        case (kind)
            K_ADD:   word = encode_r(0, 0, rd, rs1, rs2);
            K_SUB:   word = encode_r(0, 32, rd, rs1, rs2);
            K_AND:   word = encode_r(7, 0, rd, rs1, rs2);
            K_OR:    word = encode_r(6, 0, rd, rs1, rs2);
            K_XOR:   word = encode_r(4, 0, rd, rs1, rs2);
            K_ADDI:  word = encode_i(0, rd, rs1, imm);
            K_ANDI:  word = encode_i(7, rd, rs1, imm);
            K_ORI:   word = encode_i(6, rd, rs1, imm);
            K_XORI:  word = encode_i(4, rd, rs1, imm);
            K_LUI:   word = encode_u(rd, imm);
            default: word = encode_s(rs1, rs2, imm);
        endcase
        // architectural result
        case (kind)
            K_ADD:   res = a + b;
            K_SUB:   res = a - b;
            K_AND:   res = a & b;
            K_OR:    res = a | b;
            K_XOR:   res = a ^ b;
            K_ADDI:  res = a + si;
            K_ANDI:  res = a & si;
            K_ORI:   res = a | si;
            K_XORI:  res = a ^ si;
            K_LUI:   res = {imm[19:0], 12'b0};
            default: res = 32'd0;
        endcase
        if (kind == K_SB && a + si == `IO_OUT_ADDR) begin
            exp_out.push_back(b[7:0]);
        end
        if (kind != K_SB && rd != 0) begin
            ref_regs[rd] = res;
        end
        u_mem.load_word(build_pc, word);
        build_pc = build_pc + 32'd4;
        inst_total++;
    endtask

    task automatic begin_test(input string name);
        @(posedge clk_in);
        rst_n <= 1'b0;
        cur_test = name;
        u_mem.clear_mem();
        for (int i = 0; i < 32; i++) begin
            ref_regs[i] = 32'd0;
        end
        exp_out.delete();
        build_pc = 32'd0;
    endtask

    // release reset, then wait for the program stop
    task automatic run_to_stop();
        repeat (4) @(posedge clk_in);
        rst_n <= 1'b1;
        do begin
            @(posedge clk_in);
        end while (!stop_seen);
    endtask

    initial begin
        clk_in = 1'b0;
        forever #10 clk_in = ~clk_in;
    end

    always @(posedge clk_in) begin : drive_bus_inputs
        logic nxt_rdy;
        nxt_rdy = ($urandom % 8) != 0;
        // buffer-full only moves between two ready cycles, so a frozen bus stays frozen
        if (rdy_in && nxt_rdy) begin
            io_buffer_full <= ($urandom % 4) == 0;
        end
        rdy_in <= nxt_rdy;
    end

    always @(posedge clk_in) begin
        cycle_cnt++;
        if (cycle_cnt > 10 * inst_total * 8 + 200) begin
            report_error("timeout, the program stop was never written");
        end
    end

    // reset state and the fetch address sequence
    always @(posedge clk_in) begin
        if (!rst_n) begin
            rdy_seen <= 1'b0;
            last_a   <= 32'd0;
            exp_next <= 32'd1;
        end else begin
            if (!rdy_seen) begin
                assert (!mem_wr) else report_mismatch(cur_test, "mem_wr after reset", 0, mem_wr);
                assert (mem_a == 32'd0) else report_mismatch(cur_test, "first address", 0, mem_a);
            end
            if (rdy_in) begin
                rdy_seen <= 1'b1;
            end
            if (mem_a != last_a && mem_a[17:16] != 2'b11) begin
                assert (mem_a == exp_next) else report_mismatch(cur_test, "fetch address",
                                                                exp_next, mem_a);
                exp_next <= exp_next + 32'd1;
            end
            last_a <= mem_a;
        end
    end

    always @(posedge clk_in) begin
        if (rst_n && io_out_wr) begin
            if (exp_out.size() == 0) begin
                report_error("an output byte was written that the program does not make");
            end else begin
                assert (mem_dout == exp_out[0]) else report_mismatch(cur_test, "output byte",
                                                                     exp_out[0], mem_dout);
                void'(exp_out.pop_front());
            end
        end
    end

    always @(posedge clk_in) begin
        if (!rst_n) begin
            stop_seen <= 1'b0;
        end else if (io_stop_wr) begin
            assert (dbgreg_dout == ref_regs[10]) else report_mismatch(cur_test, "x10",
                                                                      ref_regs[10], dbgreg_dout);
            if (exp_out.size() != 0) begin
                report_error("program stopped before all output bytes were written");
            end else begin
                stop_seen <= 1'b1;
            end
        end
    end

    a_no_io_write_full: assert property (
        @(posedge clk_in) disable iff (!rst_n)
        mem_wr && mem_a[17:16] == 2'b11 |-> !io_buffer_full
    ) else report_error("I/O write while io_buffer_full was high");

    a_frozen_bus: assert property (
        @(posedge clk_in) disable iff (!rst_n)
        !rdy_in |=> $stable(mem_a) && $stable(mem_wr) && $stable(mem_dout) &&
                    $stable(dbgreg_dout)
    ) else report_error("bus or debug register changed while rdy_in was low");

    initial begin
        void'($urandom(32'hdb1d0540));
        rst_n          = 1'b0;
        rdy_in         = 1'b0;
        io_buffer_full = 1'b0;
        inst_total     = 0;
        cycle_cnt      = 0;

        begin_test("alu_mix");
        add_inst(K_LUI, 1, 0, 0, 32'h12345);
        add_inst(K_ADDI, 1, 1, 0, 32'h678);
        add_inst(K_ADDI, 2, 0, 0, -5);
        add_inst(K_ADD, 3, 1, 2, 0);
        add_inst(K_SUB, 4, 3, 1, 0);
        add_inst(K_XORI, 5, 2, 0, -1);
        add_inst(K_ORI, 6, 4, 0, 32'h0f0);
        add_inst(K_ANDI, 7, 3, 0, 32'h7ff);
        add_inst(K_AND, 8, 6, 7, 0);
        add_inst(K_OR, 9, 8, 5, 0);
        add_inst(K_XOR, 10, 9, 3, 0);
        add_inst(K_ADDI, 0, 0, 0, 55);
        add_inst(K_ADD, 10, 10, 0, 0);
        add_inst(K_LUI, 31, 0, 0, 32'h30);
        add_inst(K_SB, 0, 31, 10, 0);
        add_inst(K_SB, 0, 31, 0, 4);
        run_to_stop();

        begin_test("dep_chain");
        add_inst(K_ADDI, 10, 0, 0, 1);
        for (int i = 0; i < 12; i++) begin
            case (i % 4)
                0: add_inst(K_ADD, 10, 10, 10, 0);
                1: add_inst(K_ADDI, 10, 10, 0, -7);
                2: add_inst(K_XORI, 10, 10, 0, 32'h155);
                default: add_inst(K_SUB, 10, 10, 0, 0);
            endcase
        end
        add_inst(K_LUI, 31, 0, 0, 32'h30);
        add_inst(K_SB, 0, 31, 10, 0);
        add_inst(K_SB, 0, 31, 0, 4);
        run_to_stop();

        begin_test("io_bytes");
        add_inst(K_LUI, 31, 0, 0, 32'h30);
        add_inst(K_ADDI, 10, 0, 0, 32'h5a);
        for (int i = 0; i < 8; i++) begin
            add_inst(K_ADDI, 12, 0, 0, 65 + 3 * i);
            add_inst(K_SB, 0, 31, 12, 0);
        end
        add_inst(K_SB, 0, 31, 0, 4);
        run_to_stop();

        $display("** PASS **");
        $finish;
    end

endmodule

`default_nettype wire

/* sim.f */
+incdir+rtl
rtl/cpu_pkg.sv
rtl/memctrl.sv
rtl/fetcher.sv
rtl/decoder.sv
rtl/regfile.sv
rtl/execute.sv
rtl/cpu.sv
tests/tb_mem_model.sv
tests/tb_cpu.sv

/* Bender.yml */
package:
  name: cpu

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/cpu_pkg.sv
      - rtl/memctrl.sv
      - rtl/fetcher.sv
      - rtl/decoder.sv
      - rtl/regfile.sv
      - rtl/execute.sv
      - rtl/cpu.sv
  - target: test
    files:
      - tests/tb_mem_model.sv
      - tests/tb_cpu.sv
